// File: tb.f
verilog/core_pkg.sv
verilog/ctrl_fsm.sv
verilog/pc_counter.sv
verilog/idu.sv
verilog/alu.sv
verilog/exu.sv
verilog/regfile.sv
verilog/core_top.sv
+incdir+sim
sim/tb_core.sv

// File: Makefile
SRCS := $(wildcard verilog/*.sv) sim/tb_core.sv sim/tb_encode.svh tb.f

.PHONY: all run clean

all: run

obj_dir/Vtb_core: $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_core -f tb.f -o Vtb_core

run: obj_dir/Vtb_core
	obj_dir/Vtb_core | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// i-type words, used for op-imm, jalr and system.
function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

// byte offset, bit 0 is dropped by the format.
function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

function automatic logic [31:0] ebreak_word();
    return itype_word(op_system, 3'b000, 5'd0, 5'd0, 12'd1);
endfunction

`endif

// File: sim/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 4;
    localparam int idle_cycles  = 4;
    localparam int n_insts      = 50;    // executed words of both programs.

    typedef struct packed {
        logic        wen;
        logic [31:0] wdata;
        logic [31:0] next_pc;
        logic        halt;
        halt_cause_e cause;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        inst_valid = 1'b0;
    logic [31:0] inst_data = '0;
    logic        inst_req;
    logic [31:0] inst_addr;
    retire_t     retire;
    logic        halted;
    halt_cause_e halt_cause;

    logic [31:0] imem [0:63];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic [31:0] cur_inst;
    expect_t     expected;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [31:0] req_addr;

    `include "tb_encode.svh"

    always #(clk_period / 2) clk = ~clk;

    core_top core_top_inst (.clk(clk), .rst_n(rst_n), .inst_req(inst_req),
                            .inst_addr(inst_addr), .inst_valid(inst_valid),
                            .inst_data(inst_data), .retire(retire), .halted(halted),
                            .halt_cause(halt_cause));

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic fail_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // answers each request after 1 to 4 cycles.
    // the delay of the next answer is drawn ahead of its request.
    always @(posedge clk) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
            busy       <= 1'b0;
            wait_cnt   <= 2'($urandom_range(3, 0));
        end else begin
            inst_valid <= 1'b0;
            if (inst_req) req_addr <= inst_addr;
            if ((inst_req || busy) && wait_cnt == 2'd0) begin
                inst_valid <= 1'b1;
                inst_data  <= imem[inst_req ? inst_addr[7:2] : req_addr[7:2]];
                busy       <= 1'b0;
                wait_cnt   <= 2'($urandom_range(3, 0));
            end else if (inst_req || busy) begin
                busy     <= 1'b1;
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] bits;
        rd   = 5'($urandom_range(30, 0));    // x31 holds the jalr base.
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        bits = $urandom;
        case ($urandom_range(9, 0))
            0: return itype_word(op_imm, 3'b000, rd, rs1, bits[11:0]);
            1: return itype_word(op_imm, 3'b010, rd, rs1, bits[11:0]);
            2: return itype_word(op_imm, 3'b011, rd, rs1, bits[11:0]);
            3: return itype_word(op_imm, 3'b100, rd, rs1, bits[11:0]);
            4: return itype_word(op_imm, 3'b110, rd, rs1, bits[11:0]);
            5: return itype_word(op_imm, 3'b111, rd, rs1, bits[11:0]);
            6: return rtype_word(7'b0000000, 3'b000, rd, rs1, rs2);
            7: return rtype_word(7'b0100000, 3'b000, rd, rs1, rs2);
            8: return utype_word(op_lui, rd, bits[19:0]);
            default: return utype_word(op_auipc, rd, bits[19:0]);
        endcase
    endfunction

    task automatic load_prog1();
        int n;
        n = 0;
        for (int i = 0; i < 64; i++) imem[i] = 32'(i) << 7;    // opcode zero is illegal.
        for (int i = 0; i < 40; i++) begin
            imem[n] = random_inst();
            n++;
            if (i == 9 || i == 29) begin
                imem[n]     = jtype_word(5'($urandom_range(30, 0)), 21'd8);
                imem[n + 1] = random_inst();    // skipped.
                n += 2;
            end
            if (i == 19 || i == 34) begin
                // odd offset, so the target has bit 0 set before clearing.
                imem[n]     = utype_word(op_auipc, 5'd31, 20'd0);
                imem[n + 1] = itype_word(op_jalr, 3'b000, 5'($urandom_range(30, 0)),
                                         5'd31, 12'd13);
                imem[n + 2] = random_inst();
                n += 3;
            end
        end
        imem[n] = ebreak_word();
    endtask

    task automatic load_prog2();
        for (int i = 0; i < 64; i++) imem[i] = 32'(i) << 7;
        imem[0] = itype_word(op_imm, 3'b000, 5'd1, 5'd0, 12'd5);
        imem[1] = rtype_word(7'b0000000, 3'b000, 5'd2, 5'd1, 5'd1);
        imem[2] = 32'h0000_000b;    // custom-0 opcode.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic expect_t ref_exec(input logic [31:0] w, input logic [31:0] pc,
                                         input logic [31:0] v1, input logic [31:0] v2);
        expect_t     e;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        imm_i     = {{20{w[31]}}, w[31:20]};
        imm_u     = {w[31:12], 12'b0};
        e.wdata   = pc + 32'd4;
        e.next_pc = pc + 32'd4;
        e.halt    = 1'b0;
        e.cause   = cause_none;
        case (w[6:0])
            op_imm: begin
                case (w[14:12])
                    3'b000:  e.wdata = v1 + imm_i;
                    3'b010:  e.wdata = 32'($signed(v1) < $signed(imm_i));
                    3'b011:  e.wdata = 32'(v1 < imm_i);
                    3'b100:  e.wdata = v1 ^ imm_i;
                    3'b110:  e.wdata = v1 | imm_i;
                    default: e.wdata = v1 & imm_i;
                endcase
            end
            op_reg:   e.wdata = w[30] ? v1 - v2 : v1 + v2;
            op_lui:   e.wdata = imm_u;
            op_auipc: e.wdata = pc + imm_u;
            op_jal:   e.next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            op_jalr:  e.next_pc = (v1 + imm_i) & ~32'd1;
            default: begin
                e.halt    = 1'b1;
                e.next_pc = pc;
                e.cause   = (w == 32'h0010_0073) ? cause_ebreak : cause_illegal;
            end
        endcase
        e.wen = !e.halt && w[11:7] != 5'd0;
        return e;
    endfunction

    assign cur_inst = imem[model_pc[7:2]];
    assign expected = ref_exec(cur_inst, model_pc, model_regs[cur_inst[19:15]],
                               model_regs[cur_inst[24:20]]);

    always @(posedge clk) begin
        if (!rst_n) begin
            model_pc <= reset_pc;
            for (int i = 0; i < 32; i++) model_regs[i] <= '0;
        end else if (retire.valid) begin
            model_pc <= expected.next_pc;
            if (expected.wen) model_regs[cur_inst[11:7]] <= expected.wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req |-> inst_addr == model_pc) else fail_run("fetch address differs from model pc");
    a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire.pc == model_pc) else fail_run("retire pc differs from model pc");
    a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire.rd == cur_inst[11:7]) else fail_run("retire rd is wrong");
    a_retire_data: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire.wen == expected.wen && (!expected.wen ||
        retire.wdata == expected.wdata)) else fail_run("retire wen or wdata is wrong");
    a_retire_timing: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |=> retire.valid) else fail_run("no retire one cycle after inst_valid");
    a_retire_source: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> $past(inst_valid)) else fail_run("retire without a response");
    a_next_req: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && !expected.halt |=> inst_req) else fail_run("no request after retire");
    a_halt: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && expected.halt |=> halted && halt_cause == expected.cause)
        else fail_run("halted or halt_cause is wrong after a halting instruction");
    a_quiet_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !inst_req) else fail_run("inst_req while halted");

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_halt(input halt_cause_e cause);
        @(negedge clk);
        while (!halted) @(negedge clk);
        assert (halt_cause == cause) else fail_run("core halted for the wrong cause");
        repeat (idle_cycles) @(posedge clk);
    endtask

    initial begin
        #((n_insts * 8 + 2 * (reset_cycles + idle_cycles)) * clk_period);
        $display("watchdog expired before both programs halted");
        stop_run();
    end

    initial begin
        void'($urandom(32'h43e9));
        load_prog1();
        apply_reset();
        wait_halt(cause_ebreak);
        load_prog2();
        apply_reset();
        wait_halt(cause_illegal);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            inst_req,
    output logic [xlen-1:0] inst_addr,
    input  logic            inst_valid,
    input  logic [31:0]     inst_data,
    output retire_t         retire,
    output logic            halted,
    output halt_cause_e     halt_cause
);

    logic [31:0]     inst;
    decode_t         dec;
    logic            exec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] result;
    logic            wen;
    logic            jump;
    logic [xlen-1:0] target;

    ctrl_fsm ctrl_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .dec        (dec),
        .inst       (inst),
        .inst_req   (inst_req),
        .exec       (exec),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    pc_counter pc_counter_inst (.clk(clk), .rst_n(rst_n), .exec(exec), .jump(jump),
                                .target(target), .pc(pc));

    idu idu_inst (.inst(inst), .dec(dec));

    exu exu_inst (.dec(dec), .src1(src1), .src2(src2), .pc(pc), .result(result),
                  .wen(wen), .jump(jump), .target(target));

    regfile regfile_inst (.clk(clk), .rst_n(rst_n), .wen(exec && wen), .waddr(dec.rd),
                          .wdata(result), .raddr1(dec.rs1), .raddr2(dec.rs2),
                          .rdata1(src1), .rdata2(src2));

    assign inst_addr = pc;

    // trace of the instruction in st_exec.
    assign retire = '{valid: exec, pc: pc, rd: dec.rd, wen: exec && wen, wdata: result};

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wen,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [1:31];    // x0 has no storage.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    // exu already drops rd == 0, so a write to x0 means a broken wen path.
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> waddr != 5'd0);

endmodule

// File: verilog/exu.sv
`timescale 1ns/1ps

module exu import core_pkg::*; (
    input  decode_t         dec,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result,
    output logic            wen,
    output logic            jump,
    output logic [xlen-1:0] target
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] jal_target;
    logic [xlen-1:0] jalr_sum;

    // operand select.
    always_comb begin
        case (dec.opcode)
            op_imm: begin
                a = src1;
                b = dec.imm;
            end
            op_auipc: begin
                a = pc;
                b = dec.imm;
            end
            op_lui: begin
                a = '0;
                b = dec.imm;
            end
            op_jal, op_jalr: begin    // link value.
                a = pc;
                b = 32'd4;
            end
            default: begin
                a = src1;
                b = src2;
            end
        endcase
    end

    alu alu_inst (
        .a      (a),
        .b      (b),
        .op     (dec.alu_op),
        .result (result)
    );

    assign jal_target = pc + dec.imm;
    assign jalr_sum   = src1 + dec.imm;

    assign jump   = !dec.illegal && (dec.opcode == op_jal || dec.opcode == op_jalr);
    assign target = (dec.opcode == op_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : jal_target;

    // every legal non-system opcode writes rd.
    assign wen = !dec.illegal && !dec.is_ebreak && (dec.rd != 5'd0);

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result
);

    logic            sub;
    logic [xlen-1:0] b_eff;
    logic [xlen-1:0] sum;
    logic            carry;
    logic            overflow;

    assign sub   = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
    assign b_eff = sub ? ~b : b;

    // one adder; carry out set means no borrow on subtract.
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, sub};
    assign overflow     = (a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != a[xlen-1]);

    always_comb begin
        case (op)
            alu_add, alu_sub: result = sum;
            alu_slt:  result = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
            alu_sltu: result = {{(xlen-1){1'b0}}, !carry};
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = sum;
        endcase
    end

endmodule

// File: verilog/idu.sv
`timescale 1ns/1ps

module idu import core_pkg::*; (
    input  logic [31:0] inst,
    output decode_t     dec
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.opcode    = opcode_e'(inst[6:0]);
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm_i;
        dec.alu_op    = alu_add;
        dec.is_ebreak = 1'b0;
        dec.illegal   = 1'b0;
        case (inst[6:0])
            op_imm: begin
                case (funct3)
                    3'b000:  dec.alu_op = alu_add;
                    3'b010:  dec.alu_op = alu_slt;
                    3'b011:  dec.alu_op = alu_sltu;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b110:  dec.alu_op = alu_or;
                    3'b111:  dec.alu_op = alu_and;
                    default: dec.illegal = 1'b1;    // shifts.
                endcase
            end
            op_reg: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    dec.alu_op = alu_add;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    dec.alu_op = alu_sub;
                else
                    dec.illegal = 1'b1;
            end
            op_lui, op_auipc: dec.imm = imm_u;
            op_jal:           dec.imm = imm_j;
            op_jalr:          dec.illegal = (funct3 != 3'b000);
            op_system: begin
                if (funct3 == 3'b000 && inst[31:20] == 12'd1)
                    dec.is_ebreak = 1'b1;
                else
                    dec.illegal = 1'b1;    // ecall, csr and friends.
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// File: verilog/pc_counter.sv
`timescale 1ns/1ps

module pc_counter import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            exec,
    input  logic            jump,
    input  logic [xlen-1:0] target,
    output logic [xlen-1:0] pc
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (exec) begin
            pc <= jump ? target : pc + 32'd4;
        end
    end

    // targets come from exu, so this covers the jump path too.
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

// File: verilog/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst_data,
    input  decode_t     dec,
    output logic [31:0] inst,
    output logic        inst_req,
    output logic        exec,
    output logic        halted,
    output halt_cause_e halt_cause
);

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch: state_nxt = st_wait;
            st_wait:  if (inst_valid) state_nxt = st_exec;
            st_exec:  state_nxt = (dec.is_ebreak || dec.illegal) ? st_halt : st_fetch;
            default:  state_nxt = st_halt;    // stays here until reset.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_fetch;
            halt_cause <= cause_none;
        end else begin
            state <= state_nxt;
            if (state == st_exec) begin
                if (dec.illegal)
                    halt_cause <= cause_illegal;
                else if (dec.is_ebreak)
                    halt_cause <= cause_ebreak;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) inst <= inst_data;    // instruction register.
    end

    assign inst_req = (state == st_fetch);
    assign exec     = (state == st_exec);
    assign halted   = (state == st_halt);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // protocol checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_valid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> state == st_wait);

    a_req_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req |=> !inst_req);

    // once halted, no instruction may execute again.
    a_no_exec_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> !exec);

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    localparam int unsigned xlen     = 32;
    localparam logic [31:0] reset_pc = 32'h8000_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        st_fetch,
        st_wait,
        st_exec,
        st_halt
    } state_e;

    typedef enum logic [1:0] {
        cause_none,
        cause_ebreak,
        cause_illegal
    } halt_cause_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        opcode_e         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;    // already sign-extended.
        alu_op_e         alu_op;
        logic            is_ebreak;
        logic            illegal;
    } decode_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            wen;
        logic [xlen-1:0] wdata;
    } retire_t;

endpackage
